// ==== matrix_vectors.txt ====
// one test per line: num temp, then expected colg for rows 0 to 7
// colr is expected to equal colg when temp is 1, else 00
0 0 00 00 18 3c 3c 18 00 00
1 1 00 00 38 7c 7c 38 00 00
2 0 00 00 3c 7e 7e 3c 00 00
3 0 00 3c 7e 7e 7e 7e 3c 00
4 1 3c 7e ff ff ff ff 7e 3c
5 0 ff ff ff ff ff ff ff ff
6 1 c3 e3 f1 e3 c7 e7 f7 fb
7 0 00 01 81 c3 83 c7 e7 f3
8 0 00 38 44 5a 4a 32 c4 38
9 1 00 00 60 fc 3f 3e 1c 00
a 0 00 00 18 3c 7e 7e 24 00
b 1 e0 60 e0 30 31 33 3e 1c
c 0 00 00 00 00 00 00 00 00
f 1 00 00 00 00 00 00 00 00

// ==== build.f ====
matrix_pkg.sv
disp_if.sv
glyph_rom.sv
display_ctrl.sv
row_scanner.sv
matrix_driver.sv
matrix_display_top.sv
tb_matrix_display.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_matrix_display
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
VECTORS   := matrix_vectors.txt
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(VECTORS)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_matrix_display.sv ====
`timescale 1ns/1ps

module tb_matrix_display;

    localparam int row_div     = 2;
    localparam int num_vectors = 14;
    localparam int rec_len     = 10;  // num, temp, eight green rows
    localparam int frame_ns    = 8 * row_div * 4;
    localparam int limit_ns    = (num_vectors * 4 + 16) * frame_ns + 200;

    logic       clk;
    logic       rst;
    logic       st;
    logic       temp;
    logic [3:0] num;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    logic [7:0] vec_mem [0:num_vectors*rec_len-1];

    matrix_display_top #(
        .row_div (row_div)
    ) dut0 (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .temp (temp),
        .num  (num),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        #(limit_ns);
        $display("watchdog expired before all tests finished");
        $display("SIMULATION FAILED");
        $fatal(1, "run timed out");
    end

    function automatic logic [7:0] vec_green(input int v, input matrix_pkg::row_t r);
        return vec_mem[v*rec_len + 2 + int'(r)];
    endfunction

    function automatic logic vec_temp(input int v);
        return vec_mem[v*rec_len + 1][0];
    endfunction

    // codes 12..15 all map to the blank glyph
    function automatic matrix_pkg::glyph_e vec_glyph(input int v);
        if (vec_mem[v*rec_len][3:0] < 4'd12)
            return matrix_pkg::glyph_e'(vec_mem[v*rec_len][3:0]);
        return matrix_pkg::GLYPH_BLANK;
    endfunction

    function automatic matrix_pkg::row_t low_bit_index(input logic [7:0] sel);
        matrix_pkg::row_t idx;
        idx = '0;
        for (int i = 0; i < 8; i++)
            if (!sel[i])
                idx = matrix_pkg::row_t'(i);
        return idx;
    endfunction

    task automatic stop_on_value(input string what, input logic [7:0] exp_v,
                                 input logic [7:0] act_v);
        $display("FAIL %s expected 0x%h got 0x%h", what, exp_v, act_v);
        $display("SIMULATION FAILED");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_row(input logic [7:0] exp_sel);
        if (row !== exp_sel)
            stop_on_value("row", exp_sel, row);
    endtask

    task automatic check_cols(input matrix_pkg::row_t r, input matrix_pkg::glyph_e g,
                              input logic [7:0] exp_g, input logic [7:0] exp_r);
        if (colg !== exp_g)
            stop_on_value($sformatf("colg (row %0d, %s)", r, g.name()), exp_g, colg);
        if (colr !== exp_r)
            stop_on_value($sformatf("colr (row %0d, %s)", r, g.name()), exp_r, colr);
    endtask

    task automatic check_blank;
        check_row(8'hff);
        check_cols('0, matrix_pkg::GLYPH_BLANK, 8'h00, 8'h00);
    endtask

    // call right after a rising edge
    task automatic apply(input int v);
        num  <= vec_mem[v*rec_len][3:0];
        temp <= vec_mem[v*rec_len + 1][0];
    endtask

    // returns at the negedge where row 0 has just become active
    task automatic wait_row0;
        logic [7:0] prev;
        prev = row;
        @(negedge clk);
        while (!(row == 8'hfe && prev != 8'hfe))
        begin
            prev = row;
            @(negedge clk);
        end
    endtask

    // checks one frame from row 0 and loads v_next at sample swap_at if asked
    task automatic check_frame(input int v, input int swap_at, input int v_next);
        matrix_pkg::row_t idx;
        logic [7:0]       exp_g;
        int               r;
        for (int s = 0; s < 8*row_div; s++)
        begin
            if (s > 0)
            begin
                @(posedge clk);
                if (s == swap_at)
                    apply(v_next);
                @(negedge clk);
            end
            r = s / row_div;
            check_row(~(8'h01 << r));  // ascending with one row at a time
            idx   = low_bit_index(row);
            exp_g = vec_green(v, idx);
            check_cols(idx, vec_glyph(v), exp_g, vec_temp(v) ? exp_g : 8'h00);
        end
    endtask

    initial
    begin
        rst  <= 1'b1;
        st   <= 1'b0;
        temp <= 1'b0;
        num  <= 4'd0;
        $readmemh("matrix_vectors.txt", vec_mem);

        repeat (5)
        begin
            @(negedge clk);
            check_blank();
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (4)
        begin
            @(negedge clk);
            check_blank();  // st still low
        end

        @(posedge clk);
        apply(0);
        st <= 1'b1;
        for (int v = 0; v < num_vectors; v++)
        begin
            if (v > 0)
            begin
                @(posedge clk);
                apply(v);
            end
            wait_row0();
            wait_row0();
            wait_row0();
            check_frame(v, -1, 0);
        end

        // glyph change in the middle of a frame
        @(posedge clk);
        apply(6);
        wait_row0();
        wait_row0();
        wait_row0();
        check_frame(6, 4*row_div, 8);
        wait_row0();
        check_frame(8, -1, 0);

        // st low blanks after two edges
        @(posedge clk);
        st <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
        repeat (6)
        begin
            check_blank();
            @(negedge clk);
        end

        @(posedge clk);
        st <= 1'b1;
        @(negedge clk);
        while (row == 8'hff)
            @(negedge clk);
        check_frame(8, -1, 0);  // restarts at row 0

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== matrix_display_top.sv ====
`timescale 1ns/1ps

module matrix_display_top #(
    parameter int row_div = 4  // clocks per row, at least 1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       st,
    input  logic       temp,
    input  logic [3:0] num,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg
);

    disp_if disp0 ();

    display_ctrl ctrl0 (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .num  (num),
        .temp (temp),
        .disp (disp0.ctrl)
    );

    row_scanner #(
        .row_div (row_div)
    ) scan0 (
        .clk  (clk),
        .rst  (rst),
        .disp (disp0.scan)
    );

    matrix_driver drv0 (
        .clk  (clk),
        .rst  (rst),
        .disp (disp0.drv),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

endmodule

// ==== matrix_driver.sv ====
`timescale 1ns/1ps

module matrix_driver (
    input  logic       clk,
    input  logic       rst,
    disp_if.drv        disp,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg
);

    logic [matrix_pkg::matrix_size-1:0] pattern;
    logic [matrix_pkg::matrix_size-1:0] row_sel_n;

    glyph_rom rom0 (
        .glyph   (disp.glyph),
        .row_idx (disp.row_idx),
        .pattern (pattern)
    );

    // active-low one-hot row select
    assign row_sel_n = ~({{(matrix_pkg::matrix_size-1){1'b0}}, 1'b1} << disp.row_idx);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colg <= '0;
            colr <= '0;
        end
        else if (!disp.enable)
        begin
            row  <= '1;  // blank
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= row_sel_n;
            colg <= pattern;
            colr <= (disp.color == matrix_pkg::COLOR_AMBER) ? pattern : '0;
        end
    end

    // never two rows on at once
    a_row_onehot: assert property (@(posedge clk) disable iff (rst)
        (row == '1) || $onehot(~row));

endmodule

// ==== row_scanner.sv ====
`timescale 1ns/1ps

module row_scanner #(
    parameter int row_div = 4
) (
    input  logic clk,
    input  logic rst,
    disp_if.scan disp
);

    localparam int pw = (row_div > 1) ? $clog2(row_div) : 1;
    localparam logic [pw-1:0] presc_last = pw'(row_div - 1);

    logic [pw-1:0] presc;
    logic          presc_wrap;

    assign presc_wrap = (presc == presc_last);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            presc        <= '0;
            disp.row_idx <= '0;
        end
        else if (!disp.enable)
        begin
            presc        <= '0;  // park at row 0
            disp.row_idx <= '0;
        end
        else if (presc_wrap)
        begin
            presc        <= '0;
            disp.row_idx <= disp.row_idx + matrix_pkg::row_t'(1);  // 7 wraps to 0
        end
        else
        begin
            presc <= presc + pw'(1);
        end
    end

    // first cycle of row 0 including the first enabled cycle
    assign disp.frame_start = disp.enable && (presc == '0) && (disp.row_idx == '0);

    a_row_step: assert property (@(posedge clk) disable iff (rst)
        $changed(disp.row_idx) |->
            $past(presc_wrap && disp.enable) || (disp.row_idx == '0 && !$past(disp.enable)));

endmodule

// ==== display_ctrl.sv ====
`timescale 1ns/1ps

module display_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       st,
    input  logic [3:0] num,
    input  logic       temp,
    disp_if.ctrl       disp
);

    matrix_pkg::glyph_e num_glyph;
    matrix_pkg::color_e temp_color;
    matrix_pkg::glyph_e glyph_q;
    matrix_pkg::color_e color_q;

    always_comb
    begin
        if (num < 4'd12)
            num_glyph = matrix_pkg::glyph_e'(num);
        else
            num_glyph = matrix_pkg::GLYPH_BLANK;  // codes 12..15
    end

    assign temp_color = temp ? matrix_pkg::COLOR_AMBER : matrix_pkg::COLOR_GREEN;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            disp.enable <= 1'b0;
            glyph_q     <= matrix_pkg::GLYPH_BLANK;
            color_q     <= matrix_pkg::COLOR_GREEN;
        end
        else
        begin
            disp.enable <= st;
            if (!disp.enable)
            begin
                glyph_q <= matrix_pkg::GLYPH_BLANK;
                color_q <= matrix_pkg::COLOR_GREEN;
            end
            else if (disp.frame_start)
            begin
                glyph_q <= num_glyph;  // held for the whole frame
                color_q <= temp_color;
            end
        end
    end

    // the new glyph is already visible in the frame_start cycle,
    // so the driver registers row 0 with it
    always_comb
    begin
        if (!disp.enable)
        begin
            disp.glyph = matrix_pkg::GLYPH_BLANK;
            disp.color = matrix_pkg::COLOR_GREEN;
        end
        else if (disp.frame_start)
        begin
            disp.glyph = num_glyph;
            disp.color = temp_color;
        end
        else
        begin
            disp.glyph = glyph_q;
            disp.color = color_q;
        end
    end

    // latched glyph only moves at a frame boundary or while disabled
    a_glyph_stable: assert property (@(posedge clk) disable iff (rst)
        $changed({glyph_q, color_q}) |-> $past(disp.frame_start) || !$past(disp.enable));

endmodule

// ==== glyph_rom.sv ====
`timescale 1ns/1ps

module glyph_rom (
    input  matrix_pkg::glyph_e glyph,
    input  matrix_pkg::row_t   row_idx,
    output logic [7:0]         pattern
);

    always_comb
    begin
        pattern = 8'b0000_0000;
        case (glyph)
            matrix_pkg::GLYPH_0:
                case (row_idx)
                    3'd2, 3'd5: pattern = 8'b0001_1000;
                    3'd3, 3'd4: pattern = 8'b0011_1100;
                    default:    pattern = 8'b0000_0000;
                endcase
            matrix_pkg::GLYPH_1:
                case (row_idx)
                    3'd2, 3'd5: pattern = 8'b0011_1000;
                    3'd3, 3'd4: pattern = 8'b0111_1100;
                    default:    pattern = 8'b0000_0000;
                endcase
            matrix_pkg::GLYPH_2:
                case (row_idx)
                    3'd2, 3'd5: pattern = 8'b0011_1100;
                    3'd3, 3'd4: pattern = 8'b0111_1110;
                    default:    pattern = 8'b0000_0000;
                endcase
            matrix_pkg::GLYPH_3:
                case (row_idx)
                    3'd1, 3'd6:             pattern = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: pattern = 8'b0111_1110;
                    default:                pattern = 8'b0000_0000;
                endcase
            matrix_pkg::GLYPH_4:
                case (row_idx)
                    3'd0, 3'd7: pattern = 8'b0011_1100;
                    3'd1, 3'd6: pattern = 8'b0111_1110;
                    default:    pattern = 8'b1111_1111;  // rows 2..5
                endcase
            matrix_pkg::GLYPH_5: pattern = 8'b1111_1111;
            matrix_pkg::GLYPH_6:
                case (row_idx)
                    3'd0: pattern = 8'b1100_0011;
                    3'd1: pattern = 8'b1110_0011;
                    3'd2: pattern = 8'b1111_0001;
                    3'd3: pattern = 8'b1110_0011;
                    3'd4: pattern = 8'b1100_0111;
                    3'd5: pattern = 8'b1110_0111;
                    3'd6: pattern = 8'b1111_0111;
                    default: pattern = 8'b1111_1011;
                endcase
            matrix_pkg::GLYPH_7:
                case (row_idx)
                    3'd1: pattern = 8'b0000_0001;
                    3'd2: pattern = 8'b1000_0001;
                    3'd3: pattern = 8'b1100_0011;
                    3'd4: pattern = 8'b1000_0011;
                    3'd5: pattern = 8'b1100_0111;
                    3'd6: pattern = 8'b1110_0111;
                    3'd7: pattern = 8'b1111_0011;
                    default: pattern = 8'b0000_0000;
                endcase
            matrix_pkg::GLYPH_8:
                case (row_idx)
                    3'd1: pattern = 8'b0011_1000;
                    3'd2: pattern = 8'b0100_0100;
                    3'd3: pattern = 8'b0101_1010;
                    3'd4: pattern = 8'b0100_1010;
                    3'd5: pattern = 8'b0011_0010;
                    3'd6: pattern = 8'b1100_0100;
                    3'd7: pattern = 8'b0011_1000;
                    default: pattern = 8'b0000_0000;
                endcase
            matrix_pkg::GLYPH_9:
                case (row_idx)
                    3'd2: pattern = 8'b0110_0000;
                    3'd3: pattern = 8'b1111_1100;
                    3'd4: pattern = 8'b0011_1111;
                    3'd5: pattern = 8'b0011_1110;
                    3'd6: pattern = 8'b0001_1100;
                    default: pattern = 8'b0000_0000;
                endcase
            matrix_pkg::GLYPH_10:
                case (row_idx)
                    3'd2:       pattern = 8'b0001_1000;
                    3'd3:       pattern = 8'b0011_1100;
                    3'd4, 3'd5: pattern = 8'b0111_1110;
                    3'd6:       pattern = 8'b0010_0100;
                    default:    pattern = 8'b0000_0000;
                endcase
            matrix_pkg::GLYPH_11:
                case (row_idx)
                    3'd0: pattern = 8'b1110_0000;
                    3'd1: pattern = 8'b0110_0000;
                    3'd2: pattern = 8'b1110_0000;
                    3'd3: pattern = 8'b0011_0000;
                    3'd4: pattern = 8'b0011_0001;
                    3'd5: pattern = 8'b0011_0011;
                    3'd6: pattern = 8'b0011_1110;
                    default: pattern = 8'b0001_1100;
                endcase
            default: pattern = 8'b0000_0000;  // blank
        endcase
    end

endmodule

// ==== disp_if.sv ====
`timescale 1ns/1ps

interface disp_if;

    matrix_pkg::row_t   row_idx;      // current scan row
    logic               frame_start;  // first cycle of row 0
    matrix_pkg::glyph_e glyph;
    matrix_pkg::color_e color;
    logic               enable;       // registered st

    modport scan (
        output row_idx,
        output frame_start,
        input  enable
    );

    modport ctrl (
        input  frame_start,
        output glyph,
        output color,
        output enable
    );

    modport drv (
        input  row_idx,
        input  glyph,
        input  color,
        input  enable
    );

endinterface

// ==== matrix_pkg.sv ====
package matrix_pkg;

    // rows and columns of the LED matrix
    parameter int matrix_size = 8;

    // row index of the scan
    typedef logic [$clog2(matrix_size)-1:0] row_t;

    // glyph codes, 12 to 15 all show a blank frame
    typedef enum logic [3:0] {
        GLYPH_0     = 4'd0,  // small dot
        GLYPH_1     = 4'd1,
        GLYPH_2     = 4'd2,
        GLYPH_3     = 4'd3,
        GLYPH_4     = 4'd4,  // full disc
        GLYPH_5     = 4'd5,  // all on
        GLYPH_6     = 4'd6,
        GLYPH_7     = 4'd7,
        GLYPH_8     = 4'd8,
        GLYPH_9     = 4'd9,
        GLYPH_10    = 4'd10,
        GLYPH_11    = 4'd11,
        GLYPH_BLANK = 4'd12
    } glyph_e;

    // colour mode of the whole frame
    typedef enum logic {
        COLOR_GREEN = 1'b0,  // green columns only
        COLOR_AMBER = 1'b1   // red mirrors green
    } color_e;

endpackage
